// File: rvIsaPkg.sv
package rvIsaPkg;

    typedef logic [31:0] word_t;    // Data, address and instruction word
    typedef logic [4:0]  regAddr_t; // Register index
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes of the supported subset
    localparam opcode_t opcLui    = 7'b0110111;
    localparam opcode_t opcAuipc  = 7'b0010111;
    localparam opcode_t opcJal    = 7'b1101111;
    localparam opcode_t opcJalr   = 7'b1100111;
    localparam opcode_t opcBranch = 7'b1100011;
    localparam opcode_t opcLoad   = 7'b0000011;
    localparam opcode_t opcStore  = 7'b0100011;
    localparam opcode_t opcOpImm  = 7'b0010011;
    localparam opcode_t opcOp     = 7'b0110011;

    // Branch conditions
    localparam funct3_t f3Beq  = 3'b000;
    localparam funct3_t f3Bne  = 3'b001;
    localparam funct3_t f3Blt  = 3'b100;
    localparam funct3_t f3Bge  = 3'b101;
    localparam funct3_t f3Bltu = 3'b110;
    localparam funct3_t f3Bgeu = 3'b111;

    // OP and OP-IMM group
    localparam funct3_t f3Add  = 3'b000; // Also SUB on OP with bit 30
    localparam funct3_t f3Sll  = 3'b001;
    localparam funct3_t f3Slt  = 3'b010;
    localparam funct3_t f3Sltu = 3'b011;
    localparam funct3_t f3Xor  = 3'b100;
    localparam funct3_t f3Sr   = 3'b101; // SRL or SRA by bit 30
    localparam funct3_t f3Or   = 3'b110;
    localparam funct3_t f3And  = 3'b111;

    localparam word_t nopInstr = 32'h0000_0013; // addi x0, x0, 0

endpackage

// File: cpuCtrlPkg.sv
package cpuCtrlPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB   // LUI
    } aluOp_t;

    typedef enum logic [1:0] {aSelRs1, aSelPc, aSelZero} aSel_t;

    typedef enum logic {bSelRs2, bSelImm} bSel_t;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immFmt_t;

    typedef enum logic [1:0] {wbAlu, wbPc4, wbMem} wbSel_t;

    // Branch and JAL share the PC-relative target
    typedef enum logic [1:0] {pcSeq, pcTarget, pcJalr} pcSel_t;

    // Stall states of a load or store
    typedef enum logic [1:0] {memIdle, memSetup, memAccess} memState_t;

endpackage

// File: aluUnit.sv
module aluUnit (
    input  rvIsaPkg::word_t    opA,
    input  rvIsaPkg::word_t    opB,
    input  cpuCtrlPkg::aluOp_t aluOp,
    input  rvIsaPkg::funct3_t  funct3,
    output rvIsaPkg::word_t    result,
    output logic               branchTaken
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    logic [4:0] shamt;
    logic       eq, lt, ltu;

    assign shamt = opB[4:0];
    assign eq    = (opA == opB);
    assign lt    = ($signed(opA) < $signed(opB));
    assign ltu   = (opA < opB);

    always_comb begin
        case (aluOp)
            aluSub:   result = opA - opB;
            aluSll:   result = opA << shamt;
            aluSlt:   result = {31'b0, lt};
            aluSltu:  result = {31'b0, ltu};
            aluXor:   result = opA ^ opB;
            aluSrl:   result = opA >> shamt;
            aluSra:   result = word_t'($signed(opA) >>> shamt);
            aluOr:    result = opA | opB;
            aluAnd:   result = opA & opB;
            aluPassB: result = opB;
            default:  result = opA + opB; // ADD, address and link arithmetic
        endcase
    end

    // Only looked at by the control for branch opcodes
    always_comb begin
        case (funct3)
            f3Beq:   branchTaken = eq;
            f3Bne:   branchTaken = !eq;
            f3Blt:   branchTaken = lt;
            f3Bge:   branchTaken = !lt;
            f3Bltu:  branchTaken = ltu;
            f3Bgeu:  branchTaken = !ltu;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

// File: apbLoadStore.sv
module apbLoadStore (
    input  logic            CLK,
    input  logic            RST,
    input  logic            memRead,
    input  logic            memWrite,
    input  rvIsaPkg::word_t addr,
    input  rvIsaPkg::word_t wdata,
    output rvIsaPkg::word_t paddr,
    output rvIsaPkg::word_t pwdata,
    output logic            pwrite,
    output logic            psel,
    output logic            penable,
    input  rvIsaPkg::word_t prdata,
    input  logic            pready,
    output rvIsaPkg::word_t loadData,
    output logic            done
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    memState_t state;
    word_t     addrReg;
    word_t     dataReg;
    logic      writeReg;
    logic      start;

    assign start = (state == memIdle) && (memRead || memWrite);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= memIdle;
        end else begin
            case (state)
                memIdle:   if (memRead || memWrite) state <= memSetup;
                memSetup:  state <= memAccess;
                memAccess: if (pready) state <= memIdle; // Wait states
                default:   state <= memIdle;
            endcase
        end
    end

    // Held stable from SETUP through the end of ACCESS
    always_ff @(posedge CLK) begin
        if (start) begin
            addrReg  <= addr;
            dataReg  <= wdata;
            writeReg <= memWrite;
        end
    end

    assign paddr    = addrReg;
    assign pwdata   = dataReg;
    assign pwrite   = writeReg;
    assign psel     = (state != memIdle);
    assign penable  = (state == memAccess);
    assign done     = (state == memAccess) && pready;
    assign loadData = prdata; // Valid together with done

endmodule

// File: cpuControl.sv
module cpuControl (
    input  logic                CLK,
    input  logic                RST,
    input  rvIsaPkg::word_t     instr,
    input  logic                branchTaken,
    input  logic                apbDone,
    output cpuCtrlPkg::aSel_t   aSel,
    output cpuCtrlPkg::bSel_t   bSel,
    output cpuCtrlPkg::immFmt_t immFmt,
    output cpuCtrlPkg::wbSel_t  wbSel,
    output cpuCtrlPkg::pcSel_t  pcSel,
    output cpuCtrlPkg::aluOp_t  aluOp,
    output logic                regWe,
    output logic                memRead,
    output logic                memWrite,
    output logic                pcEn,
    output logic                retireValid
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    logic      alt;           // Instruction bit 30
    logic      isLoad, isStore, isBranch, isJal, isJalr;
    logic      writesRd;
    logic      complete;
    memState_t memState, memNext;

    // ALU operation of the OP and OP-IMM group
    function automatic aluOp_t aluDecode(funct3_t f3, logic altBit, logic isReg);
        case (f3)
            f3Add:   return (isReg && altBit) ? aluSub : aluAdd; // No SUBI
            f3Sll:   return aluSll;
            f3Slt:   return aluSlt;
            f3Sltu:  return aluSltu;
            f3Xor:   return aluXor;
            f3Sr:    return altBit ? aluSra : aluSrl;
            f3Or:    return aluOr;
            f3And:   return aluAnd;
            default: return aluAdd;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    always_comb begin
        aSel     = aSelRs1;
        bSel     = bSelRs2;
        immFmt   = immI;
        wbSel    = wbAlu;
        aluOp    = aluAdd;
        writesRd = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        isJal    = 1'b0;
        isJalr   = 1'b0;
        case (opcode)
            opcLui: begin
                aSel = aSelZero; bSel = bSelImm; immFmt = immU;
                aluOp = aluPassB; writesRd = 1'b1;
            end
            opcAuipc: begin
                aSel = aSelPc; bSel = bSelImm; immFmt = immU; writesRd = 1'b1;
            end
            opcJal: begin
                immFmt = immJ; wbSel = wbPc4; writesRd = 1'b1; isJal = 1'b1;
            end
            opcJalr: begin
                bSel = bSelImm; wbSel = wbPc4; writesRd = 1'b1; isJalr = 1'b1;
            end
            opcBranch: begin
                immFmt = immB; aluOp = aluSub; isBranch = 1'b1; // rs1 against rs2
            end
            opcLoad: begin
                bSel = bSelImm; wbSel = wbMem; writesRd = 1'b1; isLoad = 1'b1;
            end
            opcStore: begin
                bSel = bSelImm; immFmt = immS; isStore = 1'b1;
            end
            opcOpImm: begin
                bSel = bSelImm; aluOp = aluDecode(funct3, alt, 1'b0); writesRd = 1'b1;
            end
            opcOp: begin
                aluOp = aluDecode(funct3, alt, 1'b1); writesRd = 1'b1;
            end
            default: ; // Anything else retires as a no-op
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            memState <= memIdle;
        end else begin
            memState <= memNext;
        end
    end

    always_comb begin
        memNext = memState;
        case (memState)
            memIdle:   if (isLoad || isStore) memNext = memSetup;
            memSetup:  memNext = memAccess;
            memAccess: if (apbDone) memNext = memIdle;
            default:   memNext = memIdle;
        endcase
    end

    // Request strobe only in the fetch cycle of a load or store
    assign memRead  = isLoad && (memState == memIdle);
    assign memWrite = isStore && (memState == memIdle);

    assign complete    = (isLoad || isStore) ? (memState == memAccess && apbDone) : 1'b1;
    assign pcEn        = complete;
    assign regWe       = writesRd && complete;
    assign retireValid = complete && !RST; // Quiet while in reset

    always_comb begin
        if (isJal || (isBranch && branchTaken)) begin
            pcSel = pcTarget;
        end else if (isJalr) begin
            pcSel = pcJalr;
        end else begin
            pcSel = pcSeq;
        end
    end

endmodule

// File: immGen.sv
module immGen (
    input  rvIsaPkg::word_t     instr,
    input  cpuCtrlPkg::immFmt_t immFmt,
    output rvIsaPkg::word_t     imm
);
    import cpuCtrlPkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immFmt)
            immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            immB: imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            immU: imm = {instr[31:12], 12'b0};
            immJ: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = {{20{sign}}, instr[31:20]}; // I format
        endcase
    end

endmodule

// File: pcUnit.sv
module pcUnit #(
    parameter rvIsaPkg::word_t resetAddr = '0
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               pcEn,
    input  cpuCtrlPkg::pcSel_t pcSel,
    input  rvIsaPkg::word_t    imm,
    input  rvIsaPkg::word_t    aluResult,
    output rvIsaPkg::word_t    pc,
    output rvIsaPkg::word_t    pcPlus4
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    word_t target;   // Branch and JAL target
    word_t nextPc;

    assign pcPlus4 = pc + 32'd4;
    assign target  = pc + imm;

    always_comb begin
        case (pcSel)
            pcTarget: nextPc = target;
            pcJalr:   nextPc = {aluResult[31:1], 1'b0}; // rs1 + imm, bit 0 cleared
            default:  nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= resetAddr;
        end else if (pcEn) begin
            pc <= nextPc;
        end
    end

endmodule

// File: regFile.sv
module regFile (
    input  logic               CLK,
    input  logic               RST,
    input  rvIsaPkg::regAddr_t rs1,
    input  rvIsaPkg::regAddr_t rs2,
    input  rvIsaPkg::regAddr_t rd,
    input  logic               we,
    input  rvIsaPkg::word_t    wd,
    output rvIsaPkg::word_t    rd1,
    output rvIsaPkg::word_t    rd2
);
    import rvIsaPkg::*;

    word_t regs [0:31];

    // Asynchronous read ports
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wd; // x0 stays zero
        end
    end

endmodule

// File: singleCpu.sv
module singleCpu #(
    parameter rvIsaPkg::word_t resetAddr = '0
) (
    input  logic               CLK,
    input  logic               RST,
    // Instruction fetch
    output rvIsaPkg::word_t    imemAddr,
    input  rvIsaPkg::word_t    imemData,
    // APB master
    output rvIsaPkg::word_t    paddr,
    output logic               pwrite,
    output logic               psel,
    output logic               penable,
    output rvIsaPkg::word_t    pwdata,
    input  rvIsaPkg::word_t    prdata,
    input  logic               pready,
    // Retire trace
    output logic               retireValid,
    output rvIsaPkg::word_t    retirePc,
    output rvIsaPkg::regAddr_t retireRd,
    output logic               retireWe,
    output rvIsaPkg::word_t    retireData
);
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;

    word_t     pc, pcPlus4, imm;
    word_t     rd1, rd2;
    word_t     opA, opB, aluResult;
    word_t     loadData, wbData;
    aSel_t     aSel;
    bSel_t     bSel;
    immFmt_t   immFmt;
    wbSel_t    wbSel;
    pcSel_t    pcSel;
    aluOp_t    aluOp;
    logic      regWe, memRead, memWrite, pcEn;
    logic      branchTaken, apbDone;

    cpuControl cpuControl_i (
        .CLK(CLK), .RST(RST), .instr(imemData), .branchTaken(branchTaken), .apbDone(apbDone),
        .aSel(aSel), .bSel(bSel), .immFmt(immFmt), .wbSel(wbSel), .pcSel(pcSel),
        .aluOp(aluOp), .regWe(regWe), .memRead(memRead), .memWrite(memWrite),
        .pcEn(pcEn), .retireValid(retireValid)
    );

    pcUnit #(.resetAddr(resetAddr)) pcUnit_i (
        .CLK(CLK), .RST(RST), .pcEn(pcEn), .pcSel(pcSel), .imm(imm),
        .aluResult(aluResult), .pc(pc), .pcPlus4(pcPlus4)
    );

    regFile regFile_i (
        .CLK(CLK), .RST(RST), .rs1(imemData[19:15]), .rs2(imemData[24:20]),
        .rd(imemData[11:7]), .we(regWe), .wd(wbData), .rd1(rd1), .rd2(rd2)
    );

    immGen immGen_i (.instr(imemData), .immFmt(immFmt), .imm(imm));

    aluUnit aluUnit_i (
        .opA(opA), .opB(opB), .aluOp(aluOp), .funct3(imemData[14:12]),
        .result(aluResult), .branchTaken(branchTaken)
    );

    apbLoadStore apbLoadStore_i (
        .CLK(CLK), .RST(RST), .memRead(memRead), .memWrite(memWrite),
        .addr(aluResult), .wdata(rd2), .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite),
        .psel(psel), .penable(penable), .prdata(prdata), .pready(pready),
        .loadData(loadData), .done(apbDone)
    );

    // Operand and writeback selection
    always_comb begin
        case (aSel)
            aSelPc:   opA = pc;
            aSelZero: opA = '0;
            default:  opA = rd1;
        endcase
        opB = (bSel == bSelImm) ? imm : rd2;
        case (wbSel)
            wbPc4:   wbData = pcPlus4; // Link value
            wbMem:   wbData = loadData;
            default: wbData = aluResult;
        endcase
    end

    assign imemAddr   = pc;
    assign retirePc   = pc;
    assign retireRd   = imemData[11:7];
    assign retireWe   = regWe;
    assign retireData = wbData;

endmodule

// File: rvRefModel.sv
module rvRefModel #(
    parameter rvIsaPkg::word_t resetAddr = '0
) ();
    timeunit 1ns;
    timeprecision 100ps;
    import rvIsaPkg::*;

    word_t regs [0:31];  // Architectural state
    word_t mem  [0:63];
    word_t pc;

    task automatic clear();
        pc = resetAddr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = '0;
        end
    endtask

    function automatic word_t arith(funct3_t f3, word_t a, word_t b, logic alt);
        case (f3)
            f3Add:   return alt ? a - b : a + b;
            f3Sll:   return a << b[4:0];
            f3Slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3Sltu:  return (a < b) ? 32'd1 : 32'd0;
            f3Xor:   return a ^ b;
            f3Sr:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            f3Or:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic taken(funct3_t f3, word_t a, word_t b);
        case (f3)
            f3Beq:   return a == b;
            f3Bne:   return a != b;
            f3Blt:   return $signed(a) < $signed(b);
            f3Bge:   return $signed(a) >= $signed(b);
            f3Bltu:  return a < b;
            f3Bgeu:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // One instruction, returns what the retire port should show
    task automatic step(input word_t instr, output word_t thisPc, output regAddr_t rd,
                        output logic we, output word_t data, output logic isMem,
                        output logic isStore, output word_t addr, output word_t wdata);
        word_t a, b, immI, immS, immB, immJ, immU, nextPc;
        funct3_t f3;
        a = regs[instr[19:15]];
        b = regs[instr[24:20]];
        f3 = instr[14:12];
        immI = {{20{instr[31]}}, instr[31:20]};
        immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        immU = {instr[31:12], 12'b0};
        thisPc = pc;
        rd = instr[11:7];
        we = 1'b0;
        data = '0;
        isMem = 1'b0;
        isStore = 1'b0;
        addr = '0;
        wdata = b;
        nextPc = pc + 32'd4;
        case (instr[6:0])
            opcLui:   begin
                we = 1'b1;
                data = immU;
            end
            opcAuipc: begin
                we = 1'b1;
                data = pc + immU;
            end
            opcJal:   begin
                we = 1'b1;
                data = pc + 32'd4;
                nextPc = pc + immJ;
            end
            opcJalr:  begin
                we = 1'b1;
                data = pc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            opcBranch: begin
                if (taken(f3, a, b)) begin
                    nextPc = pc + immB;
                end
            end
            opcLoad:  begin
                isMem = 1'b1;
                we = 1'b1;
                addr = a + immI;
                data = mem[addr[7:2]];
            end
            opcStore: begin
                isMem = 1'b1;
                isStore = 1'b1;
                addr = a + immS;
                mem[addr[7:2]] = b;
            end
            opcOpImm: begin
                we = 1'b1;
                data = arith(f3, a, immI, instr[30] && (f3 == f3Sr)); // No SUBI
            end
            opcOp:    begin
                we = 1'b1;
                data = arith(f3, a, b, instr[30]);
            end
            default:  ;
        endcase
        if (we && rd != '0) begin
            regs[rd] = data;    // x0 stays zero
        end
        pc = nextPc;
    endtask

endmodule

// File: singleCpuTb.sv
module singleCpuTb;
    timeunit 1ns;
    timeprecision 100ps;
    import rvIsaPkg::*;

    localparam word_t resetAddr = 32'h0000_0000;
    localparam int    romWords  = 256;
    localparam word_t romBytes  = romWords * 4;
    localparam int    periodNs  = 20;
    localparam int    limitNs   = romWords * 5 * periodNs + 50 * periodNs; // Plus reset and slack

    logic     CLK;
    logic     RST;
    word_t    imemAddr, imemData;
    word_t    paddr, pwdata, prdata;
    logic     pwrite, psel, penable, pready;
    logic     retireValid, retireWe;
    word_t    retirePc, retireData;
    regAddr_t retireRd;

    word_t    rom [0:romWords-1];
    word_t    slaveMem [0:63];
    int       seed = 65;
    int       retired = 0;
    int       apbPhase = 0;     // 0 idle, 1 setup, 2 waiting, 3 finished
    word_t    heldAddr, heldData, lastImemAddr;
    logic     heldWrite;
    word_t    instr, expPc, expData, expAddr, expWdata;
    regAddr_t expRd;
    logic     expWe, expMem, expStore;

    singleCpu #(.resetAddr(resetAddr)) singleCpu_i (
        .CLK(CLK), .RST(RST), .imemAddr(imemAddr), .imemData(imemData),
        .paddr(paddr), .pwrite(pwrite), .psel(psel), .penable(penable), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .retireValid(retireValid), .retirePc(retirePc),
        .retireRd(retireRd), .retireWe(retireWe), .retireData(retireData)
    );

    rvRefModel #(.resetAddr(resetAddr)) refModel_i ();

    function automatic word_t fetchWord(word_t addr);
        if (addr < romBytes) begin
            return rom[addr[9:2]];
        end
        return nopInstr; // Past the end of the ROM
    endfunction

    assign imemData = fetchWord(imemAddr);

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkReg(input string name, input regAddr_t got, input regAddr_t exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Random program with forward-only control flow
    task automatic buildProgram();
        word_t       r, u;
        regAddr_t    rd, rs1, rs2;
        funct3_t     f3;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        for (int i = 0; i < romWords; i++) begin
            r = $random(seed);
            u = $random(seed);
            rd = {2'b00, r[10:8]};
            rs1 = {2'b00, r[13:11]};
            rs2 = {2'b00, r[16:14]};
            f3 = r[19:17];
            boff = 13'(4 * (int'(r[22:20]) + 1)); // 4 to 32 bytes
            joff = 21'(boff);
            case (r[26:23])
                4'd0: rom[i] = {u[31:12], rd, opcLui};
                4'd1: rom[i] = {u[31:12], rd, opcAuipc};
                4'd2: rom[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, opcJal};
                4'd3: begin
                    imm12 = 12'(i * 4 + int'(boff) + int'(u[0])); // Odd target now and then
                    rom[i] = {imm12, 5'd0, 3'b000, rd, opcJalr};
                end
                4'd4, 4'd5: begin
                    if (f3[2:1] == 2'b01) begin
                        f3[2] = 1'b1;
                    end
                    rom[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], opcBranch};
                end
                4'd6: rom[i] = {4'b0, u[7:2], 2'b00, 5'd0, 3'b010, rd, opcLoad};
                4'd7: rom[i] = {4'b0, u[7:5], rs2, 5'd0, 3'b010, u[4:2], 2'b00, opcStore};
                4'd11, 4'd12, 4'd13: begin
                    rom[i] = {1'b0, u[30] && (f3 == f3Add || f3 == f3Sr), 5'b0,
                              rs2, rs1, f3, rd, opcOp};
                end
                4'd14: rom[i] = {u[31:7], 7'b1110011}; // Unsupported, retires as no-op
                default: begin
                    imm12 = u[11:0];
                    if (f3 == f3Sll || f3 == f3Sr) begin
                        imm12 = {1'b0, u[30] && (f3 == f3Sr), 5'b0, u[4:0]};
                    end
                    rom[i] = {imm12, rs1, f3, rd, opcOpImm};
                end
            endcase
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #(periodNs / 2) CLK = ~CLK;
    end

    // APB slave with 0 to 3 wait states
    initial begin
        int waitLeft;
        pready = 1'b0;
        prdata = '0;
        waitLeft = 0;
        for (int i = 0; i < 64; i++) begin
            slaveMem[i] = '0;
        end
        forever begin
            @(posedge CLK);
            #2;
            pready = 1'b0;
            if (psel && !penable) begin
                waitLeft = $random(seed) & 3;
            end else if (psel && penable) begin
                if (waitLeft == 0) begin
                    pready = 1'b1;
                    if (pwrite) begin
                        slaveMem[paddr[7:2]] = pwdata;
                    end else begin
                        prdata = slaveMem[paddr[7:2]];
                    end
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    initial begin
        #(limitNs);
        abortRun($sformatf("Watchdog expired after %0d ns with %0d retired", limitNs, retired));
    end

    initial begin
        RST = 1'b1;
        buildProgram();
        refModel_i.clear();
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        checkBit("psel", psel, 1'b0);
        checkBit("penable", penable, 1'b0);
        checkBit("retireValid", retireValid, 1'b0);
        checkWord("imemAddr", imemAddr, resetAddr);
        @(posedge CLK);
        #2;
        RST = 1'b0;
        lastImemAddr = resetAddr;

        while (refModel_i.pc < romBytes) begin
            @(negedge CLK);
            if (penable && !psel) begin
                abortRun("APB penable went high without psel");
            end
            if (psel && !penable) begin
                if (apbPhase != 0) begin
                    abortRun("APB SETUP phase did not start from idle");
                end
                heldAddr = paddr;
                heldData = pwdata;
                heldWrite = pwrite;
                apbPhase = 1;
            end else if (psel && penable) begin
                if (apbPhase != 1 && apbPhase != 2) begin
                    abortRun("APB ACCESS phase without a SETUP cycle before it");
                end
                checkWord("paddr", paddr, heldAddr);
                checkWord("pwdata", pwdata, heldData);
                checkBit("pwrite", pwrite, heldWrite);
                apbPhase = pready ? 3 : 2;
            end else begin
                apbPhase = 0;
            end
            // Core stalls until the slave answers
            if (psel && !(penable && pready)) begin
                checkBit("retireValid", retireValid, 1'b0);
                checkWord("imemAddr", imemAddr, lastImemAddr);
            end
            if (retireValid) begin
                instr = fetchWord(refModel_i.pc);
                refModel_i.step(instr, expPc, expRd, expWe, expData, expMem, expStore,
                                expAddr, expWdata);
                checkWord("retirePc", retirePc, expPc);
                checkBit("retireWe", retireWe, expWe);
                if (expWe) begin
                    checkReg("retireRd", retireRd, expRd);
                    checkWord("retireData", retireData, expData);
                end
                if (expMem) begin
                    if (!(psel && penable && pready)) begin
                        abortRun("Load or store retired outside a completing APB ACCESS");
                    end
                    checkBit("pwrite", pwrite, expStore);
                    checkWord("paddr", paddr, expAddr);
                    if (expStore) begin
                        checkWord("pwdata", pwdata, expWdata);
                    end
                end
                retired++;
            end
            lastImemAddr = imemAddr;
        end
        $display("%0d instructions retired", retired);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: singleCpu.f
rvIsaPkg.sv
cpuCtrlPkg.sv
aluUnit.sv
apbLoadStore.sv
cpuControl.sv
immGen.sv
pcUnit.sv
regFile.sv
singleCpu.sv
rvRefModel.sv
singleCpuTb.sv

// File: Bender.yml
package:
  name: singleCpu

sources:
  - rvIsaPkg.sv
  - cpuCtrlPkg.sv
  - aluUnit.sv
  - apbLoadStore.sv
  - cpuControl.sv
  - immGen.sv
  - pcUnit.sv
  - regFile.sv
  - singleCpu.sv
  - target: test
    files:
      - rvRefModel.sv
      - singleCpuTb.sv
